//--- mmc_types_pkg.sv
// MMC host engine data types

package mmc_types_pkg;

   // Frame and data widths
   typedef logic [47:0] cmd_frame_t;
   typedef logic [7:0]  data_byte_t;

   // Bit counter, large enough for the 100-bit power-up sequence
   typedef logic [7:0]  bit_count_t;

   // Host operations
   typedef enum logic [2:0] {
      OP_NONE,
      OP_INIT,
      OP_SEND,
      OP_WR,
      OP_RD,
      OP_STOP
   } mmc_op_e;

   // Engine sequencing states
   typedef enum logic [3:0] {
      ST_IDLE,
      ST_CMD_LOAD,
      ST_CMD_SHIFT,
      ST_WR_SHIFT,
      ST_RD_SHIFT,
      ST_INIT_CLK,
      ST_INIT_WAIT,
      ST_STOP_CS,
      ST_STOP_CLK,
      ST_DONE_BIT,
      ST_DONE_A,
      ST_DONE_B
   } mmc_state_e;

   // Latched host request
   typedef struct packed {
      mmc_op_e    op;
      cmd_frame_t cmd;
      data_byte_t wdata;
   } mmc_req_t;

   // Pin levels requested by the engine
   typedef struct packed {
      logic cs_level;
      logic do_level;
      logic sclk_enable;
   } pin_ctl_t;

endpackage

//--- mmc_timing_pkg.sv
// MMC bit timing definitions

package mmc_timing_pkg;

   // Position within one bit period, in clk cycles
   typedef logic [15:0] tick_count_t;

   // Bit period markers
   typedef struct packed {
      logic mid;
      logic last;
      logic in_quarter_window;
   } bit_tick_t;

   // Default system clock and serial bit rates, in Hz
   parameter int unsigned DEFAULT_FREQ    = 40_625_000;
   parameter int unsigned DEFAULT_RATE_HI = 10_000_000;
   parameter int unsigned DEFAULT_RATE_LO = 100_000;

endpackage

//--- mmc_host_req.sv
// MMC host request capture

module mmc_host_req (
   input  logic                      clk,
   input  logic                      mmc_reset,
   input  logic                      init,
   input  logic                      send,
   input  logic                      wr,
   input  logic                      rd,
   input  logic                      stop,
   input  mmc_types_pkg::cmd_frame_t cmd,
   input  mmc_types_pkg::data_byte_t data_in,
   input  logic                      busy,
   output mmc_types_pkg::mmc_req_t   req,
   output logic                      req_valid,
   output logic                      done
);

   mmc_types_pkg::mmc_op_e sel_op;
   logic                   pending;
   logic                   accept;

   // Strobe priority: init, send, wr, rd, stop
   always_comb begin
      if (init)
         sel_op = mmc_types_pkg::OP_INIT;
      else if (send)
         sel_op = mmc_types_pkg::OP_SEND;
      else if (wr)
         sel_op = mmc_types_pkg::OP_WR;
      else if (rd)
         sel_op = mmc_types_pkg::OP_RD;
      else if (stop)
         sel_op = mmc_types_pkg::OP_STOP;
      else
         sel_op = mmc_types_pkg::OP_NONE;
   end

   assign accept = (sel_op != mmc_types_pkg::OP_NONE) && !busy && !pending;

   // Pending covers the gap until the engine reports busy
   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         pending   <= 1'b0;
         req_valid <= 1'b0;
      end else begin
         req_valid <= accept;
         if (accept)
            pending <= 1'b1;
         else if (busy)
            pending <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         req <= '{op: sel_op, cmd: cmd, wdata: data_in};
   end

   assign done = !busy && !pending;

   // A new request may only reach an idle engine
   a_no_req_while_busy: assert property (
      @(posedge clk) disable iff (mmc_reset) req_valid |-> !busy)
      else $error("req_valid raised while engine busy");

endmodule

//--- mmc_bit_timer.sv
// MMC serial bit timer

module mmc_bit_timer #(
   parameter int unsigned FREQ    = mmc_timing_pkg::DEFAULT_FREQ,
   parameter int unsigned RATE_HI = mmc_timing_pkg::DEFAULT_RATE_HI,
   parameter int unsigned RATE_LO = mmc_timing_pkg::DEFAULT_RATE_LO
) (
   input  logic                      clk,
   input  logic                      mmc_reset,
   input  logic                      speed,
   input  logic                      hold,
   output mmc_timing_pkg::bit_tick_t tick,
   output logic                      fast
);

   ////////////////////////////////////////////////////////////////////////////
   // Bit widths and match points

   localparam int unsigned W_HI = FREQ / RATE_HI;
   localparam int unsigned W_LO = FREQ / RATE_LO;

   // Flags are registered, so each match sits one count early
   localparam mmc_timing_pkg::tick_count_t HI_MID =
      mmc_timing_pkg::tick_count_t'(W_HI / 2 - 1);
   localparam mmc_timing_pkg::tick_count_t HI_END =
      mmc_timing_pkg::tick_count_t'(W_HI - 2);
   localparam mmc_timing_pkg::tick_count_t LO_MID =
      mmc_timing_pkg::tick_count_t'(W_LO / 2 - 1);
   localparam mmc_timing_pkg::tick_count_t LO_END =
      mmc_timing_pkg::tick_count_t'(W_LO - 2);
   localparam mmc_timing_pkg::tick_count_t LO_Q1 =
      mmc_timing_pkg::tick_count_t'(W_LO / 4 - 1);
   localparam mmc_timing_pkg::tick_count_t LO_Q3 =
      mmc_timing_pkg::tick_count_t'(W_LO - W_LO / 4 - 1);

   ////////////////////////////////////////////////////////////////////////////
   // Counter and tick flags

   mmc_timing_pkg::tick_count_t count;
   mmc_timing_pkg::tick_count_t mid_match;
   mmc_timing_pkg::tick_count_t end_match;

   assign mid_match = fast ? HI_MID : LO_MID;
   assign end_match = fast ? HI_END : LO_END;

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         count <= '0;
         fast  <= 1'b0;
      end else begin
         fast <= speed;
         if (hold || tick.last)
            count <= '0;
         else
            count <= count + 16'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         tick <= '0;
      end else begin
         tick.mid               <= (count == mid_match);
         tick.last              <= (count == end_match);
         tick.in_quarter_window <= (count >= LO_Q1) && (count <= LO_Q3);
      end
   end

   a_mid_last_apart: assert property (
      @(posedge clk) disable iff (mmc_reset) !(tick.mid && tick.last))
      else $error("bit middle and bit end flagged together");

endmodule

//--- mmc_spi_engine.sv
// MMC SPI operation sequencer

module mmc_spi_engine (
   input  logic                      clk,
   input  logic                      mmc_reset,
   input  mmc_types_pkg::mmc_req_t   req,
   input  logic                      req_valid,
   input  mmc_timing_pkg::bit_tick_t tick,
   input  logic                      sample,
   input  logic                      mmc_di,
   output logic                      busy,
   output logic                      hold,
   output mmc_types_pkg::pin_ctl_t   pins,
   output mmc_types_pkg::data_byte_t data_out
);

   // Index of the final bit in each phase
   localparam mmc_types_pkg::bit_count_t INIT_CLK_LAST  = mmc_types_pkg::bit_count_t'(79);
   localparam mmc_types_pkg::bit_count_t INIT_WAIT_LAST = mmc_types_pkg::bit_count_t'(99);
   localparam mmc_types_pkg::bit_count_t CMD_LAST       = mmc_types_pkg::bit_count_t'(47);
   localparam mmc_types_pkg::bit_count_t BYTE_LAST      = mmc_types_pkg::bit_count_t'(7);

   mmc_types_pkg::mmc_state_e state;
   mmc_types_pkg::mmc_state_e state_next;
   mmc_types_pkg::bit_count_t bit_cnt;
   mmc_types_pkg::cmd_frame_t cmd_sr;
   mmc_types_pkg::data_byte_t byte_sr;
   logic                      cs_q;
   logic                      line_hi;
   logic                      counting;
   logic                      take;

   assign take = (state == mmc_types_pkg::ST_IDLE) && req_valid;

   ////////////////////////////////////////////////////////////////////////////
   // Next state

   always_comb begin
      state_next = state;
      unique case (state)
         mmc_types_pkg::ST_IDLE: begin
            if (req_valid) begin
               unique case (req.op)
                  mmc_types_pkg::OP_INIT: state_next = mmc_types_pkg::ST_INIT_CLK;
                  mmc_types_pkg::OP_SEND: state_next = mmc_types_pkg::ST_CMD_LOAD;
                  mmc_types_pkg::OP_WR:   state_next = mmc_types_pkg::ST_WR_SHIFT;
                  mmc_types_pkg::OP_RD:   state_next = mmc_types_pkg::ST_RD_SHIFT;
                  mmc_types_pkg::OP_STOP: state_next = mmc_types_pkg::ST_STOP_CS;
                  default:                state_next = mmc_types_pkg::ST_IDLE;
               endcase
            end
         end
         mmc_types_pkg::ST_CMD_LOAD:
            state_next = mmc_types_pkg::ST_CMD_SHIFT;
         mmc_types_pkg::ST_CMD_SHIFT:
            if (tick.last && bit_cnt == CMD_LAST)
               state_next = mmc_types_pkg::ST_DONE_BIT;
         mmc_types_pkg::ST_WR_SHIFT,
         mmc_types_pkg::ST_RD_SHIFT,
         mmc_types_pkg::ST_STOP_CLK:
            if (tick.last && bit_cnt == BYTE_LAST)
               state_next = mmc_types_pkg::ST_DONE_BIT;
         mmc_types_pkg::ST_INIT_CLK:
            if (tick.last && bit_cnt == INIT_CLK_LAST)
               state_next = mmc_types_pkg::ST_INIT_WAIT;
         mmc_types_pkg::ST_INIT_WAIT:
            if (tick.last && bit_cnt == INIT_WAIT_LAST)
               state_next = mmc_types_pkg::ST_DONE_BIT;
         // One full bit of chip select before the idle clocks
         mmc_types_pkg::ST_STOP_CS:
            if (tick.last)
               state_next = mmc_types_pkg::ST_STOP_CLK;
         mmc_types_pkg::ST_DONE_BIT:
            state_next = mmc_types_pkg::ST_DONE_A;
         mmc_types_pkg::ST_DONE_A:
            state_next = mmc_types_pkg::ST_DONE_B;
         default:
            state_next = mmc_types_pkg::ST_IDLE;
      endcase
   end

   always_comb begin
      unique case (state)
         mmc_types_pkg::ST_CMD_SHIFT,
         mmc_types_pkg::ST_WR_SHIFT,
         mmc_types_pkg::ST_RD_SHIFT,
         mmc_types_pkg::ST_INIT_CLK,
         mmc_types_pkg::ST_INIT_WAIT,
         mmc_types_pkg::ST_STOP_CLK: counting = 1'b1;
         default:                    counting = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control registers

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         state    <= mmc_types_pkg::ST_IDLE;
         bit_cnt  <= '0;
         cs_q     <= 1'b0;
         line_hi  <= 1'b0;
         data_out <= '0;
      end else begin
         state <= state_next;
         if (state == mmc_types_pkg::ST_IDLE)
            bit_cnt <= '0;
         else if (counting && tick.last)
            bit_cnt <= bit_cnt + 8'd1;
         // Chip select follows the last operation that set it
         if (take && (req.op == mmc_types_pkg::OP_INIT || req.op == mmc_types_pkg::OP_STOP))
            cs_q <= 1'b1;
         else if (take && req.op == mmc_types_pkg::OP_SEND)
            cs_q <= 1'b0;
         // Data line rests high once any operation has run
         if (state == mmc_types_pkg::ST_DONE_BIT)
            line_hi <= 1'b1;
         if (take && req.op == mmc_types_pkg::OP_RD)
            data_out <= '0;
         else if (state == mmc_types_pkg::ST_RD_SHIFT && sample)
            data_out <= {data_out[6:0], mmc_di};
      end
   end

   // Transmit shifters, MSB first
   always_ff @(posedge clk) begin
      if (take) begin
         cmd_sr  <= req.cmd;
         byte_sr <= req.wdata;
      end else if (tick.last) begin
         if (state == mmc_types_pkg::ST_CMD_SHIFT)
            cmd_sr <= {cmd_sr[46:0], 1'b0};
         if (state == mmc_types_pkg::ST_WR_SHIFT)
            byte_sr <= {byte_sr[6:0], 1'b0};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pin requests

   always_comb begin
      pins.cs_level = cs_q;
      unique case (state)
         mmc_types_pkg::ST_CMD_LOAD,
         mmc_types_pkg::ST_CMD_SHIFT: pins.do_level = cmd_sr[47];
         mmc_types_pkg::ST_WR_SHIFT:  pins.do_level = byte_sr[7];
         mmc_types_pkg::ST_IDLE:      pins.do_level = line_hi;
         default:                     pins.do_level = 1'b1;
      endcase
      unique case (state)
         mmc_types_pkg::ST_CMD_SHIFT,
         mmc_types_pkg::ST_WR_SHIFT,
         mmc_types_pkg::ST_RD_SHIFT,
         mmc_types_pkg::ST_INIT_CLK,
         mmc_types_pkg::ST_STOP_CLK: pins.sclk_enable = 1'b1;
         default:                    pins.sclk_enable = 1'b0;
      endcase
   end

   assign busy = (state != mmc_types_pkg::ST_IDLE);
   assign hold = (state == mmc_types_pkg::ST_IDLE) || (state == mmc_types_pkg::ST_CMD_LOAD);

   a_bit_cnt_range: assert property (
      @(posedge clk) disable iff (mmc_reset) bit_cnt <= 8'd100)
      else $error("bit count beyond power-up length");

endmodule

//--- mmc_pins.sv
// MMC serial pin driver

module mmc_pins (
   input  logic                      clk,
   input  logic                      mmc_reset,
   input  mmc_types_pkg::pin_ctl_t   pins,
   input  mmc_timing_pkg::bit_tick_t tick,
   input  logic                      fast,
   output logic                      mmc_cs,
   output logic                      mmc_do,
   output logic                      mmc_sclk,
   output logic                      sample
);

   logic sclk_next;

   // Fast: high from bit middle to bit end
   // Slow: high inside the quarter window
   always_comb begin
      if (!pins.sclk_enable) begin
         sclk_next = 1'b0;
      end else if (fast) begin
         if (tick.mid)
            sclk_next = 1'b1;
         else if (tick.last)
            sclk_next = 1'b0;
         else
            sclk_next = mmc_sclk;
      end else begin
         sclk_next = tick.in_quarter_window;
      end
   end

   always_ff @(posedge clk) begin
      if (mmc_reset) begin
         mmc_cs   <= 1'b0;
         mmc_do   <= 1'b0;
         mmc_sclk <= 1'b0;
      end else begin
         mmc_cs   <= pins.cs_level;
         mmc_do   <= pins.do_level;
         mmc_sclk <= sclk_next;
      end
   end

   // Receive strobe while the clock is high, once per bit
   assign sample = pins.sclk_enable && (fast ? (mmc_sclk && tick.last) : tick.mid);

endmodule

//--- mmc_spi_top.sv
// MMC SPI host top level

module mmc_spi_top #(
   parameter int unsigned FREQ    = mmc_timing_pkg::DEFAULT_FREQ,
   parameter int unsigned RATE_HI = mmc_timing_pkg::DEFAULT_RATE_HI,
   parameter int unsigned RATE_LO = mmc_timing_pkg::DEFAULT_RATE_LO
) (
   input  logic                      clk,
   input  logic                      mmc_reset,
   input  mmc_types_pkg::cmd_frame_t cmd,
   input  mmc_types_pkg::data_byte_t data_in,
   input  logic                      init,
   input  logic                      send,
   input  logic                      wr,
   input  logic                      rd,
   input  logic                      stop,
   input  logic                      speed,
   output logic                      done,
   output mmc_types_pkg::data_byte_t data_out,
   output logic                      mmc_cs,
   output logic                      mmc_do,
   output logic                      mmc_sclk,
   input  logic                      mmc_di
);

   mmc_types_pkg::mmc_req_t   req;
   mmc_types_pkg::pin_ctl_t   pins;
   mmc_timing_pkg::bit_tick_t tick;
   logic                      req_valid;
   logic                      busy;
   logic                      hold;
   logic                      fast;
   logic                      sample;

   mmc_host_req u_req (
      .clk       (clk),
      .mmc_reset (mmc_reset),
      .init      (init),
      .send      (send),
      .wr        (wr),
      .rd        (rd),
      .stop      (stop),
      .cmd       (cmd),
      .data_in   (data_in),
      .busy      (busy),
      .req       (req),
      .req_valid (req_valid),
      .done      (done)
   );

   mmc_bit_timer #(
      .FREQ    (FREQ),
      .RATE_HI (RATE_HI),
      .RATE_LO (RATE_LO)
   ) u_timer (
      .clk       (clk),
      .mmc_reset (mmc_reset),
      .speed     (speed),
      .hold      (hold),
      .tick      (tick),
      .fast      (fast)
   );

   mmc_spi_engine u_engine (
      .clk       (clk),
      .mmc_reset (mmc_reset),
      .req       (req),
      .req_valid (req_valid),
      .tick      (tick),
      .sample    (sample),
      .mmc_di    (mmc_di),
      .busy      (busy),
      .hold      (hold),
      .pins      (pins),
      .data_out  (data_out)
   );

   mmc_pins u_pins (
      .clk       (clk),
      .mmc_reset (mmc_reset),
      .pins      (pins),
      .tick      (tick),
      .fast      (fast),
      .mmc_cs    (mmc_cs),
      .mmc_do    (mmc_do),
      .mmc_sclk  (mmc_sclk),
      .sample    (sample)
   );

endmodule

//--- tb_clock.sv
// Testbench clock and reset

module tb_clock #(
   parameter int unsigned PERIOD       = 100,
   parameter int unsigned RESET_CYCLES = 16
) (
   output logic clk,
   output logic mmc_reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset released on a rising edge, like any other synchronous input
   initial begin
      mmc_reset <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      mmc_reset <= 1'b0;
   end

endmodule

//--- mmc_card_model.sv
// Behavioural MMC card

module mmc_card_model (
   input  logic                      mmc_cs,
   input  logic                      mmc_do,
   input  logic                      mmc_sclk,
   input  logic                      arm,
   input  mmc_types_pkg::data_byte_t read_byte,
   output logic                      mmc_di,
   output logic [15:0]               edge_count,
   output logic [15:0]               hi_edges,
   output mmc_types_pkg::cmd_frame_t capture,
   output logic                      cs_at_edge
);
   timeunit 1ns;
   timeprecision 100ps;

   // Card data line idles high until a read byte is loaded
   mmc_types_pkg::data_byte_t tx_sr = 8'hff;

   // Card samples its input on the rising serial clock
   always @(posedge mmc_sclk or posedge arm) begin
      if (arm) begin
         edge_count <= '0;
         hi_edges   <= '0;
         capture    <= '0;
         cs_at_edge <= 1'b0;
      end else begin
         edge_count <= edge_count + 16'd1;
         // Power-up clocks want both lines high
         if (mmc_cs && mmc_do)
            hi_edges <= hi_edges + 16'd1;
         capture    <= {capture[46:0], mmc_do};
         cs_at_edge <= mmc_cs;
      end
   end

   // Read byte goes out MSB first with the next bit after each falling edge
   always @(negedge mmc_sclk or posedge arm) begin
      if (arm)
         tx_sr <= read_byte;
      else
         tx_sr <= {tx_sr[6:0], 1'b1};
   end

   assign mmc_di = tx_sr[7];

endmodule

//--- mmc_spi_tb.sv
// MMC SPI host testbench

module mmc_spi_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned FREQ    = 16;
   localparam int unsigned RATE_HI = 4;
   localparam int unsigned RATE_LO = 1;

   // All tests take about 3200 cycles at these rates, init alone 1600
   localparam int unsigned CYCLE_LIMIT = 4000;
   localparam int unsigned DONE_LIMIT  = 2000;
   localparam logic [31:0] RAND_SEED   = 32'h50df_ecb9;

   logic                      clk;
   logic                      mmc_reset;
   mmc_types_pkg::cmd_frame_t cmd;
   mmc_types_pkg::data_byte_t data_in;
   logic                      init;
   logic                      send;
   logic                      wr;
   logic                      rd;
   logic                      stop;
   logic                      speed;
   logic                      done;
   mmc_types_pkg::data_byte_t data_out;
   logic                      mmc_cs;
   logic                      mmc_do;
   logic                      mmc_sclk;
   logic                      mmc_di;

   // Card model controls and observations
   logic                      arm;
   mmc_types_pkg::data_byte_t card_byte;
   logic [15:0]               edge_count;
   logic [15:0]               hi_edges;
   mmc_types_pkg::cmd_frame_t capture;
   logic                      cs_at_edge;

   int unsigned errors = 0;
   int unsigned errors_at_start = 0;
   int unsigned tests_run = 0;
   int unsigned tests_failed = 0;
   int unsigned cycles = 0;

   tb_clock #(.PERIOD(100), .RESET_CYCLES(16)) clock0 (
      .clk       (clk),
      .mmc_reset (mmc_reset)
   );

   mmc_spi_top #(
      .FREQ    (FREQ),
      .RATE_HI (RATE_HI),
      .RATE_LO (RATE_LO)
   ) dut0 (
      .clk       (clk),
      .mmc_reset (mmc_reset),
      .cmd       (cmd),
      .data_in   (data_in),
      .init      (init),
      .send      (send),
      .wr        (wr),
      .rd        (rd),
      .stop      (stop),
      .speed     (speed),
      .done      (done),
      .data_out  (data_out),
      .mmc_cs    (mmc_cs),
      .mmc_do    (mmc_do),
      .mmc_sclk  (mmc_sclk),
      .mmc_di    (mmc_di)
   );

   mmc_card_model card0 (
      .mmc_cs     (mmc_cs),
      .mmc_do     (mmc_do),
      .mmc_sclk   (mmc_sclk),
      .arm        (arm),
      .read_byte  (card_byte),
      .mmc_di     (mmc_di),
      .edge_count (edge_count),
      .hi_edges   (hi_edges),
      .capture    (capture),
      .cs_at_edge (cs_at_edge)
   );

   // Watchdog
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles with tests still running", CYCLE_LIMIT);
         $display("tests failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic begin_test();
      errors_at_start = errors;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: FAIL with %0d mismatches", name, errors - errors_at_start);
      end
   endtask

   // Clears the card counters and loads its read byte
   task automatic arm_card(input mmc_types_pkg::data_byte_t value);
      @(posedge clk);
      card_byte <= value;
      arm       <= 1'b1;
      @(posedge clk);
      arm <= 1'b0;
   endtask

   task automatic raise_strobe(input mmc_types_pkg::mmc_op_e op);
      case (op)
         mmc_types_pkg::OP_INIT: init <= 1'b1;
         mmc_types_pkg::OP_SEND: send <= 1'b1;
         mmc_types_pkg::OP_WR:   wr   <= 1'b1;
         mmc_types_pkg::OP_RD:   rd   <= 1'b1;
         mmc_types_pkg::OP_STOP: stop <= 1'b1;
         default: ;
      endcase
   endtask

   task automatic drop_strobes();
      init <= 1'b0;
      send <= 1'b0;
      wr   <= 1'b0;
      rd   <= 1'b0;
      stop <= 1'b0;
   endtask

   // One-cycle strobe, then done must be low
   task automatic issue_op(input mmc_types_pkg::mmc_op_e op, input logic fast_mode,
                           input mmc_types_pkg::cmd_frame_t frame,
                           input mmc_types_pkg::data_byte_t wbyte);
      @(posedge clk);
      speed <= fast_mode;
      @(posedge clk);
      cmd     <= frame;
      data_in <= wbyte;
      raise_strobe(op);
      @(posedge clk);
      drop_strobes();
      @(posedge clk);
      check_value("done", 64'd0, 64'(done));
   endtask

   task automatic wait_for_done();
      int unsigned n;
      n = 0;
      while (done !== 1'b1 && n < DONE_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (done !== 1'b1) begin
         $display("done stayed low for %0d cycles after the request", DONE_LIMIT);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests

   task automatic after_reset();
      begin_test();
      @(posedge clk);
      while (mmc_reset !== 1'b0)
         @(posedge clk);
      @(posedge clk);
      check_value("done", 64'd1, 64'(done));
      check_value("mmc_cs", 64'd0, 64'(mmc_cs));
      check_value("mmc_do", 64'd0, 64'(mmc_do));
      check_value("mmc_sclk", 64'd0, 64'(mmc_sclk));
      check_value("data_out", 64'd0, 64'(data_out));
      finish_test("after_reset");
   endtask

   task automatic power_up_init();
      begin_test();
      arm_card(8'hff);
      issue_op(mmc_types_pkg::OP_INIT, 1'b0, '0, '0);
      wait_for_done();
      check_value("sclk edges", 64'd80, 64'(edge_count));
      check_value("edges with mmc_cs and mmc_do high", 64'd80, 64'(hi_edges));
      check_value("capture", 64'h0000_ffff_ffff_ffff, 64'(capture));
      check_value("mmc_cs", 64'd1, 64'(mmc_cs));
      finish_test("init_slow");
   endtask

   task automatic send_command(input logic fast_mode);
      logic [63:0]               wide;
      mmc_types_pkg::cmd_frame_t frame;
      begin_test();
      wide  = {$urandom(), $urandom()};
      frame = wide[47:0];
      arm_card(8'hff);
      issue_op(mmc_types_pkg::OP_SEND, fast_mode, frame, '0);
      wait_for_done();
      check_value("sclk edges", 64'd48, 64'(edge_count));
      check_value("capture", 64'(frame), 64'(capture));
      check_value("mmc_cs at sclk", 64'd0, 64'(cs_at_edge));
      finish_test(fast_mode ? "send_fast" : "send_slow");
   endtask

   task automatic write_byte(input logic fast_mode);
      logic [31:0]               raw;
      mmc_types_pkg::data_byte_t wbyte;
      begin_test();
      raw   = $urandom();
      wbyte = raw[7:0];
      arm_card(8'hff);
      issue_op(mmc_types_pkg::OP_WR, fast_mode, '0, wbyte);
      wait_for_done();
      check_value("sclk edges", 64'd8, 64'(edge_count));
      check_value("capture byte", 64'(wbyte), 64'(capture[7:0]));
      finish_test(fast_mode ? "wr_fast" : "wr_slow");
   endtask

   task automatic read_byte(input logic fast_mode);
      logic [31:0]               raw;
      mmc_types_pkg::data_byte_t rbyte;
      begin_test();
      raw   = $urandom();
      rbyte = raw[7:0];
      arm_card(rbyte);
      issue_op(mmc_types_pkg::OP_RD, fast_mode, '0, '0);
      wait_for_done();
      check_value("sclk edges", 64'd8, 64'(edge_count));
      check_value("data_out", 64'(rbyte), 64'(data_out));
      finish_test(fast_mode ? "rd_fast" : "rd_slow");
   endtask

   // Stop in slow mode, with a write strobe raised mid-way
   task automatic stop_and_ignore();
      begin_test();
      arm_card(8'hff);
      issue_op(mmc_types_pkg::OP_STOP, 1'b0, '0, '0);
      repeat (20) @(posedge clk);
      check_value("done", 64'd0, 64'(done));
      wr <= 1'b1;
      @(posedge clk);
      wr <= 1'b0;
      wait_for_done();
      check_value("sclk edges", 64'd8, 64'(edge_count));
      check_value("mmc_cs", 64'd1, 64'(mmc_cs));
      check_value("mmc_cs at sclk", 64'd1, 64'(cs_at_edge));
      // Three slow bits of quiet show the write was dropped
      repeat (48) @(posedge clk);
      check_value("sclk edges", 64'd8, 64'(edge_count));
      check_value("done", 64'd1, 64'(done));
      finish_test("stop_ignore");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence

   initial begin
      logic [31:0] first_draw;
      first_draw = $urandom(RAND_SEED);
      init      <= 1'b0;
      send      <= 1'b0;
      wr        <= 1'b0;
      rd        <= 1'b0;
      stop      <= 1'b0;
      speed     <= 1'b0;
      cmd       <= '0;
      data_in   <= '0;
      arm       <= 1'b0;
      card_byte <= '0;

      after_reset();
      power_up_init();
      send_command(1'b0);
      send_command(1'b1);
      write_byte(1'b0);
      write_byte(1'b1);
      read_byte(1'b0);
      read_byte(1'b1);
      stop_and_ignore();

      $display("summary: %0d run, %0d failing, %0d mismatches",
               tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

//--- verilog.f
mmc_types_pkg.sv
mmc_timing_pkg.sv
mmc_host_req.sv
mmc_bit_timer.sv
mmc_spi_engine.sv
mmc_pins.sv
mmc_spi_top.sv
tb_clock.sv
mmc_card_model.sv
mmc_spi_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MMC SPI host simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module mmc_spi_tb -f verilog.f -o mmc_spi_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/mmc_spi_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
   exit 0
fi
exit 1
